// ==== hdl/oled_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Shared definitions for the SSD1331 hex display controller.
// Panel geometry, state types, init command table and digit font.
// ~~~~~~~~~~~~~~~~~~~~
package oled_pkg;

  localparam int OLED_WIDTH  = 96;
  localparam int OLED_HEIGHT = 64;
  localparam int TEXT_ROWS   = 16; // Digit band at scale 2.
  localparam int DIGITS      = 8;
  localparam int CELL_WIDTH  = 12;
  localparam int INIT_LEN    = 38;

  typedef logic [7:0] pixel_t; // RGB332.

  typedef enum logic [1:0] {
    ADDR_VALUE = 2'd0,
    ADDR_FG    = 2'd1,
    ADDR_BG    = 2'd2
  } reg_addr_e;

  typedef enum logic [1:0] {
    S_RESET,
    S_WAKE,
    S_INIT,
    S_PIXELS
  } seq_state_e;

  // ~~~~~~~~~~~~~~~~~~~~
  // Panel init commands sent with D/C low.
  // ~~~~~~~~~~~~~~~~~~~~
  function automatic logic [7:0] init_byte(input logic [5:0] idx);
    case (idx)
      6'd0:  return 8'hAE; // Display off.
      6'd1:  return 8'h2E; // Scrolling off.
      6'd2:  return 8'hA0; // Remap for 256 colour mode.
      6'd3:  return 8'h20;
      6'd4:  return 8'hA1; // Start line.
      6'd5:  return 8'h00;
      6'd6:  return 8'hA2; // Vertical offset.
      6'd7:  return 8'h00;
      6'd8:  return 8'hA4; // Normal display.
      6'd9:  return 8'hA8; // Multiplex 1/64.
      6'd10: return 8'h3F;
      6'd11: return 8'hAD; // External Vcc.
      6'd12: return 8'h8E;
      6'd13: return 8'hB0; // Power save off.
      6'd14: return 8'h0B;
      6'd15: return 8'hB1; // Phase lengths.
      6'd16: return 8'h31;
      6'd17: return 8'hB3; // Clock divider and oscillator.
      6'd18: return 8'hF0;
      6'd19: return 8'h8A; // Precharge A, B, C.
      6'd20: return 8'h64;
      6'd21: return 8'h8B;
      6'd22: return 8'h78;
      6'd23: return 8'h8C;
      6'd24: return 8'h64;
      6'd25: return 8'h81; // Contrast A, B, C.
      6'd26: return 8'h91;
      6'd27: return 8'h82;
      6'd28: return 8'h50;
      6'd29: return 8'h83;
      6'd30: return 8'h7D;
      6'd31: return 8'h15; // Columns 0 to 95.
      6'd32: return 8'h00;
      6'd33: return 8'h5F;
      6'd34: return 8'h75; // Rows 0 to 63.
      6'd35: return 8'h00;
      6'd36: return 8'h3F;
      6'd37: return 8'hAF; // Display on.
      default: return 8'hE3; // NOP.
    endcase
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~
  // 5x8 hex font with a blank row 7.
  // ~~~~~~~~~~~~~~~~~~~~
  function automatic logic [4:0] font_row(input logic [3:0] digit, input logic [2:0] row);
    logic [34:0] glyph;
    case (digit)
      4'h0: glyph = {5'b01110, 5'b10001, 5'b10011, 5'b10101, 5'b11001, 5'b10001, 5'b01110};
      4'h1: glyph = {5'b00100, 5'b01100, 5'b00100, 5'b00100, 5'b00100, 5'b00100, 5'b01110};
      4'h2: glyph = {5'b01110, 5'b10001, 5'b00001, 5'b00010, 5'b00100, 5'b01000, 5'b11111};
      4'h3: glyph = {5'b11111, 5'b00010, 5'b00100, 5'b00010, 5'b00001, 5'b10001, 5'b01110};
      4'h4: glyph = {5'b00010, 5'b00110, 5'b01010, 5'b10010, 5'b11111, 5'b00010, 5'b00010};
      4'h5: glyph = {5'b11111, 5'b10000, 5'b11110, 5'b00001, 5'b00001, 5'b10001, 5'b01110};
      4'h6: glyph = {5'b00110, 5'b01000, 5'b10000, 5'b11110, 5'b10001, 5'b10001, 5'b01110};
      4'h7: glyph = {5'b11111, 5'b00001, 5'b00010, 5'b00100, 5'b01000, 5'b01000, 5'b01000};
      4'h8: glyph = {5'b01110, 5'b10001, 5'b10001, 5'b01110, 5'b10001, 5'b10001, 5'b01110};
      4'h9: glyph = {5'b01110, 5'b10001, 5'b10001, 5'b01111, 5'b00001, 5'b00010, 5'b01100};
      4'hA: glyph = {5'b01110, 5'b10001, 5'b10001, 5'b10001, 5'b11111, 5'b10001, 5'b10001};
      4'hB: glyph = {5'b11110, 5'b10001, 5'b10001, 5'b11110, 5'b10001, 5'b10001, 5'b11110};
      4'hC: glyph = {5'b01110, 5'b10001, 5'b10000, 5'b10000, 5'b10000, 5'b10001, 5'b01110};
      4'hD: glyph = {5'b11100, 5'b10010, 5'b10001, 5'b10001, 5'b10001, 5'b10010, 5'b11100};
      4'hE: glyph = {5'b11111, 5'b10000, 5'b10000, 5'b11110, 5'b10000, 5'b10000, 5'b11111};
      default: glyph = {5'b11111, 5'b10000, 5'b10000, 5'b11110, 5'b10000, 5'b10000, 5'b10000};
    endcase
    if (row == 3'd7)
    begin
      return 5'b00000;
    end
    return glyph[34 - 5 * row -: 5]; // Top row in the high bits.
  endfunction

endpackage

// ==== hdl/oled_byte_if.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Byte link from a byte source to the SPI shifter.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

interface oled_byte_if;

  logic [7:0] byte_data;
  logic       byte_dc;   // High for pixel data.
  logic       start;     // One cycle only while busy is low.
  logic       busy;

  modport source (
    output byte_data, byte_dc, start,
    input  busy
  );

  modport shifter (
    input  byte_data, byte_dc, start,
    output busy
  );

endinterface

// ==== hdl/oled_spi_tx.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// SPI mode 3 byte shifter that sends MSB first.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module oled_spi_tx #(
  parameter int CLK_DIV = 2
) (
  input  logic          clk,
  input  logic          rst,
  oled_byte_if.shifter  link,
  output logic          oled_clk,
  output logic          oled_mosi,
  output logic          oled_dc
);

  localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

  logic [DIV_W-1:0] div_cnt;
  logic [3:0]       half_cnt; // 16 half periods per byte.
  logic [7:0]       shreg;
  logic             busy_q;
  logic             sclk_q;
  logic             dc_q;
  logic             half_done;

  assign half_done = (div_cnt == DIV_W'(CLK_DIV - 1));

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy_q   <= 1'b0;
      sclk_q   <= 1'b1; // Idle high.
      dc_q     <= 1'b0;
      div_cnt  <= '0;
      half_cnt <= '0;
      shreg    <= '0;
    end
    else if (!busy_q)
    begin
      if (link.start)
      begin
        shreg    <= link.byte_data;
        dc_q     <= link.byte_dc;
        busy_q   <= 1'b1;
        div_cnt  <= '0;
        half_cnt <= '0;
      end
    end
    else if (half_done)
    begin
      div_cnt  <= '0;
      half_cnt <= half_cnt + 4'd1;
      sclk_q   <= ~sclk_q;
      // Next bit on each falling edge after the first.
      if (!half_cnt[0] && half_cnt != 4'd0)
        shreg <= {shreg[6:0], 1'b0};
      if (half_cnt == 4'd15)
        busy_q <= 1'b0; // Last rising edge.
    end
    else
      div_cnt <= div_cnt + 1'b1;
  end

  assign link.busy = busy_q;
  assign oled_clk  = sclk_q;
  assign oled_mosi = shreg[7];
  assign oled_dc   = dc_q;

endmodule

// ==== hdl/oled_cmd_seq.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Panel reset, init command sequence and handover to pixels.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module oled_cmd_seq import oled_pkg::*; #(
  parameter int RESET_CYCLES = 8
) (
  input  logic         clk,
  input  logic         rst,
  oled_byte_if.source  link,
  output logic         pixel_go,
  input  pixel_t       pixel_data,
  input  logic         pixel_start,
  output logic         oled_csn,
  output logic         oled_resn
);

  localparam int RST_W = $clog2(RESET_CYCLES + 1);

  seq_state_e       state;
  logic [RST_W-1:0] rst_cnt;
  logic [5:0]       init_idx;
  logic             init_left;

  assign init_left = (init_idx != 6'(INIT_LEN));

  // ~~~~~~~~~~~~~~~~~~~~
  // Sequencer FSM.
  // ~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state    <= S_RESET;
      rst_cnt  <= '0;
      init_idx <= '0;
    end
    else
    begin
      case (state)
        S_RESET:
        begin
          if (rst_cnt == RST_W'(RESET_CYCLES - 1))
            state <= S_WAKE;
          else
            rst_cnt <= rst_cnt + 1'b1;
        end
        S_WAKE: state <= S_INIT;
        S_INIT:
        begin
          if (init_left)
          begin
            if (!link.busy)
              init_idx <= init_idx + 6'd1; // Byte starts this cycle.
          end
          else if (!link.busy)
            state <= S_PIXELS; // Last command fully sent.
        end
        S_PIXELS: state <= S_PIXELS;
      endcase
    end
  end

  assign pixel_go  = (state == S_PIXELS);
  assign oled_resn = (state != S_RESET);
  assign oled_csn  = (state == S_RESET) || (state == S_WAKE);

  // Link driven by the table, then by the renderer.
  assign link.byte_data = pixel_go ? pixel_data : init_byte(init_idx);
  assign link.byte_dc   = pixel_go;
  assign link.start     = pixel_go ? pixel_start
                                   : (state == S_INIT) && init_left && !link.busy;

endmodule

// ==== hdl/oled_hex_render.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Pixel walker and hex digit renderer that runs one byte ahead.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module oled_hex_render import oled_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        pixel_go,
  input  logic        busy,
  input  logic [31:0] value,
  input  pixel_t      fg_color,
  input  pixel_t      bg_color,
  output pixel_t      pixel_data,
  output logic        pixel_start
);

  logic [6:0]  x;
  logic [5:0]  y;
  logic        pix_valid;
  pixel_t      pix_q;
  logic [31:0] snap_value;
  pixel_t      snap_fg;
  pixel_t      snap_bg;
  logic        at_origin;
  logic        load;
  logic [31:0] cur_value;
  pixel_t      cur_fg;
  pixel_t      cur_bg;
  logic [2:0]  digit;
  logic [3:0]  cell_col;
  logic [2:0]  glyph_col;
  logic [3:0]  nibble;
  logic [4:0]  glyph_bits;
  pixel_t      next_pixel;

  assign at_origin = (x == 7'd0) && (y == 6'd0);
  assign load      = pixel_go && !pix_valid;

  // Frame start uses the live registers, later pixels the snapshot.
  assign cur_value = at_origin ? value : snap_value;
  assign cur_fg    = at_origin ? fg_color : snap_fg;
  assign cur_bg    = at_origin ? bg_color : snap_bg;

  // ~~~~~~~~~~~~~~~~~~~~
  // Pixel rule.
  // ~~~~~~~~~~~~~~~~~~~~
  always_comb
  begin
    digit      = 3'(x / 7'(CELL_WIDTH));
    cell_col   = 4'(x % 7'(CELL_WIDTH));
    glyph_col  = cell_col[3:1]; // Scale 2.
    nibble     = cur_value[4 * (DIGITS - 1 - digit) +: 4];
    glyph_bits = font_row(nibble, y[3:1]);
    if (y >= 6'(TEXT_ROWS) || glyph_col == 3'd5)
      next_pixel = cur_bg;
    else if (glyph_bits[3'd4 - glyph_col])
      next_pixel = cur_fg;
    else
      next_pixel = cur_bg;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      x         <= '0;
      y         <= '0;
      pix_valid <= 1'b0;
    end
    else if (load)
      pix_valid <= 1'b1;
    else if (pixel_start)
    begin
      pix_valid <= 1'b0;
      if (x == 7'(OLED_WIDTH - 1))
      begin
        x <= '0;
        y <= (y == 6'(OLED_HEIGHT - 1)) ? 6'd0 : y + 6'd1;
      end
      else
        x <= x + 7'd1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      pix_q <= next_pixel;
      if (at_origin)
      begin
        snap_value <= value;
        snap_fg    <= fg_color;
        snap_bg    <= bg_color;
      end
    end
  end

  assign pixel_data  = pix_q;
  assign pixel_start = pixel_go && pix_valid && !busy;

endmodule

// ==== hdl/oled_regs.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Value and colour registers for the renderer.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module oled_regs import oled_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        wr_en,
  input  reg_addr_e   addr,
  input  logic [31:0] wdata,
  output logic [31:0] value,
  output pixel_t      fg_color,
  output pixel_t      bg_color
);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      value    <= 32'h0000_0000;
      fg_color <= 8'hFF; // White on black.
      bg_color <= 8'h00;
    end
    else if (wr_en)
    begin
      case (addr)
        ADDR_VALUE: value <= wdata;
        ADDR_FG:    fg_color <= wdata[7:0];
        ADDR_BG:    bg_color <= wdata[7:0];
        default:
        begin
          // Address 3 is unused.
        end
      endcase
    end
  end

endmodule

// ==== hdl/oled_hex_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// SSD1331 hex value display, top level.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module oled_hex_top import oled_pkg::*; #(
  parameter int CLK_DIV      = 2,
  parameter int RESET_CYCLES = 8
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        wr_en,
  input  logic [1:0]  addr,
  input  logic [31:0] wdata,
  output logic        oled_csn,
  output logic        oled_clk,
  output logic        oled_mosi,
  output logic        oled_dc,
  output logic        oled_resn
);

  logic [31:0] value;
  pixel_t      fg_color;
  pixel_t      bg_color;
  pixel_t      pixel_data;
  logic        pixel_start;
  logic        pixel_go;

  oled_byte_if byte_link ();

  oled_regs regs_i (
    .clk      (clk),
    .rst      (rst),
    .wr_en    (wr_en),
    .addr     (reg_addr_e'(addr)),
    .wdata    (wdata),
    .value    (value),
    .fg_color (fg_color),
    .bg_color (bg_color)
  );

  oled_hex_render render_i (
    .clk         (clk),
    .rst         (rst),
    .pixel_go    (pixel_go),
    .busy        (byte_link.busy),
    .value       (value),
    .fg_color    (fg_color),
    .bg_color    (bg_color),
    .pixel_data  (pixel_data),
    .pixel_start (pixel_start)
  );

  oled_cmd_seq #(
    .RESET_CYCLES (RESET_CYCLES)
  ) seq_i (
    .clk         (clk),
    .rst         (rst),
    .link        (byte_link.source),
    .pixel_go    (pixel_go),
    .pixel_data  (pixel_data),
    .pixel_start (pixel_start),
    .oled_csn    (oled_csn),
    .oled_resn   (oled_resn)
  );

  oled_spi_tx #(
    .CLK_DIV (CLK_DIV)
  ) spi_i (
    .clk       (clk),
    .rst       (rst),
    .link      (byte_link.shifter),
    .oled_clk  (oled_clk),
    .oled_mosi (oled_mosi),
    .oled_dc   (oled_dc)
  );

endmodule

// ==== bench/tb_clock.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Testbench clock source.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module tb_clock #(
  parameter int PERIOD_NS = 4
) (
  output logic clk
);

  initial
  begin
    clk = 1'b0;
    forever
      #(PERIOD_NS / 2) clk = ~clk; // 50 percent duty.
  end

endmodule

// ==== bench/oled_hex_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Testbench for the SSD1331 hex display controller.
// Decodes the SPI pins and checks init bytes and three frames.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module oled_hex_tb import oled_pkg::*; ();

  localparam int CLK_DIV      = 2;
  localparam int RESET_CYCLES = 8;
  localparam int FRAME_BYTES  = OLED_WIDTH * OLED_HEIGHT;
  localparam int BYTE_CYCLES  = 16 * CLK_DIV + 8; // Busy time plus gap margin.
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + 16 + (INIT_LEN + 5 * FRAME_BYTES) * BYTE_CYCLES;

  logic        clk;
  logic        rst;
  logic        wr_en;
  logic [1:0]  addr;
  logic [31:0] wdata;
  logic        oled_csn;
  logic        oled_clk;
  logic        oled_mosi;
  logic        oled_dc;
  logic        oled_resn;

  logic [15:0] lfsr = 16'd95;
  logic [31:0] model_value = 32'h0;
  pixel_t      model_fg = 8'hFF;
  pixel_t      model_bg = 8'h00;
  logic        mon_armed = 1'b0;
  logic [7:0]  shift_byte = 8'h00;
  int          bit_cnt = 0;
  logic [8:0]  rx_q[$]; // {dc, byte}.
  int          frame_no = 0;
  int          pix_no = 0;

  tb_clock #(.PERIOD_NS(4)) clock_i (.clk(clk));

  oled_hex_top #(
    .CLK_DIV      (CLK_DIV),
    .RESET_CYCLES (RESET_CYCLES)
  ) dut_i (
    .clk       (clk),
    .rst       (rst),
    .wr_en     (wr_en),
    .addr      (addr),
    .wdata     (wdata),
    .oled_csn  (oled_csn),
    .oled_clk  (oled_clk),
    .oled_mosi (oled_mosi),
    .oled_dc   (oled_dc),
    .oled_resn (oled_resn)
  );

  // ~~~~~~~~~~~~~~~~~~~~
  // Reference model.
  // ~~~~~~~~~~~~~~~~~~~~
  function automatic logic [7:0] expected_init(input int i);
    return init_byte(6'(i));
  endfunction

  function automatic pixel_t expected_pixel(input int x, input int y, input logic [31:0] v,
                                            input pixel_t fg, input pixel_t bg);
    int         d;
    int         c;
    logic [3:0] nib;
    logic [4:0] row_bits;
    if (y >= TEXT_ROWS)
      return bg;
    d = x / CELL_WIDTH;
    c = (x % CELL_WIDTH) / 2; // Scale 2.
    if (c == 5)
      return bg; // Spacing column.
    nib      = v[4 * (DIGITS - 1 - d) +: 4];
    row_bits = font_row(nib, 3'(y / 2));
    return row_bits[4 - c] ? fg : bg;
  endfunction

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // x^16+x^14+x^13+x^11+1.
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] r);
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_next(lfsr);
      r    = {r[30:0], lfsr[0]};
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // Checks.
  // ~~~~~~~~~~~~~~~~~~~~
  task automatic fail_now(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  task automatic check_cmd(input string name, input int idx, input logic [7:0] exp,
                           input logic [7:0] act);
    if (act !== exp)
      fail_now($sformatf("CHECK FAILED %s[%0d]: expected 8'h%02h, actual 8'h%02h",
                         name, idx, exp, act));
  endtask

  task automatic check_pixel(input string name, input pixel_t exp, input pixel_t act);
    if (act !== exp)
      fail_now($sformatf("CHECK FAILED %s: expected 8'h%02h, actual 8'h%02h", name, exp, act));
  endtask

  task automatic check_level(input string name, input logic exp, input logic act);
    if (act !== exp)
      fail_now($sformatf("CHECK FAILED %s: expected %b, actual %b", name, exp, act));
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // SPI pin monitor.
  // ~~~~~~~~~~~~~~~~~~~~
  always @(oled_clk)
  begin
    if (mon_armed && oled_csn !== 1'b0)
      fail_now("oled_clk toggled while oled_csn was high");
  end

  always @(posedge oled_clk)
  begin
    if (mon_armed && oled_csn === 1'b0)
    begin
      shift_byte = {shift_byte[6:0], oled_mosi}; // MSB first.
      bit_cnt    = bit_cnt + 1;
      if (bit_cnt == 8)
      begin
        rx_q.push_back({oled_dc, shift_byte});
        bit_cnt = 0;
      end
    end
  end

  task automatic next_byte(output logic [7:0] b, output logic dc);
    logic [8:0] item;
    while (rx_q.size() == 0)
      @(posedge clk);
    item = rx_q.pop_front();
    dc   = item[8];
    b    = item[7:0];
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // Stimulus.
  // ~~~~~~~~~~~~~~~~~~~~
  task automatic write_reg(input logic [1:0] a, input logic [31:0] d);
    @(posedge clk);
    wr_en <= 1'b1;
    addr  <= a;
    wdata <= d;
    @(posedge clk);
    wr_en <= 1'b0;
    if (a == ADDR_VALUE)
      model_value = d;
    else if (a == ADDR_FG)
      model_fg = d[7:0];
    else if (a == ADDR_BG)
      model_bg = d[7:0];
  endtask

  initial
  begin : stimulus
    logic [31:0] rnd;
    rst   = 1'b1;
    wr_en = 1'b0;
    addr  = 2'd0;
    wdata = 32'h0;
    @(posedge clk);
    @(negedge clk);
    check_level("reset oled_csn", 1'b1, oled_csn);
    check_level("reset oled_resn", 1'b0, oled_resn);
    check_level("reset oled_clk", 1'b1, oled_clk);
    check_level("reset oled_dc", 1'b0, oled_dc);
    @(posedge clk);
    rst       <= 1'b0;
    mon_armed <= 1'b1;
    repeat (RESET_CYCLES)
    begin
      @(negedge clk);
      check_level("panel reset oled_csn", 1'b1, oled_csn);
      check_level("panel reset oled_resn", 1'b0, oled_resn);
    end
    @(negedge clk);
    check_level("wake oled_resn", 1'b1, oled_resn);
    check_level("wake oled_csn", 1'b1, oled_csn);
    @(negedge clk);
    check_level("init oled_csn", 1'b0, oled_csn);

    while (frame_no < 1 || pix_no < 200)
      @(posedge clk);
    draw_bits(32, rnd);
    write_reg(ADDR_VALUE, rnd);
    draw_bits(8, rnd);
    write_reg(ADDR_FG, rnd);
    draw_bits(8, rnd);
    write_reg(ADDR_BG, rnd);

    while (frame_no < 2 || pix_no < 200)
      @(posedge clk);
    draw_bits(32, rnd);
    write_reg(2'd3, rnd); // Unused address.
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Byte compare.
  // ~~~~~~~~~~~~~~~~~~~~
  initial
  begin : compare_bytes
    logic [7:0]  b;
    logic        dc;
    logic [31:0] snap_value;
    pixel_t      snap_fg;
    pixel_t      snap_bg;
    for (int i = 0; i < INIT_LEN; i++)
    begin
      next_byte(b, dc);
      check_level($sformatf("init byte %0d oled_dc", i), 1'b0, dc);
      check_cmd("init command", i, expected_init(i), b);
    end
    $display("Init sequence of %0d bytes matched", INIT_LEN);
    for (int f = 1; f <= 3; f++)
    begin
      snap_value = model_value; // Registers seen at frame start.
      snap_fg    = model_fg;
      snap_bg    = model_bg;
      frame_no   = f;
      for (int y = 0; y < OLED_HEIGHT; y++)
        for (int x = 0; x < OLED_WIDTH; x++)
        begin
          pix_no = y * OLED_WIDTH + x;
          next_byte(b, dc);
          check_level($sformatf("frame %0d pixel (%0d,%0d) oled_dc", f, x, y), 1'b1, dc);
          check_pixel($sformatf("frame %0d pixel (%0d,%0d)", f, x, y),
                      expected_pixel(x, y, snap_value, snap_fg, snap_bg), b);
        end
      $display("Frame %0d matched, value %08h fg %02h bg %02h", f, snap_value, snap_fg, snap_bg);
    end
    $display("Result: PASSED");
    $finish;
  end

  initial
  begin : watchdog
    repeat (TIMEOUT_CYCLES)
      @(posedge clk);
    fail_now($sformatf("Timeout after %0d cycles without finishing all frames",
                       TIMEOUT_CYCLES));
  end

endmodule

// ==== build.f ====
hdl/oled_pkg.sv
hdl/oled_byte_if.sv
hdl/oled_spi_tx.sv
hdl/oled_cmd_seq.sv
hdl/oled_hex_render.sv
hdl/oled_regs.sv
hdl/oled_hex_top.sv
bench/tb_clock.sv
bench/oled_hex_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the SSD1331 hex display testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f build.f --top-module oled_hex_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Voled_hex_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -q "^Result: PASSED$"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
